// ==== flist.f ====
rtl/cpu_pkg.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/forward_unit.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/mem_stage.sv
rtl/pipeline_top.sv
sim/tb_pipeline.sv

// ==== sim/tb_pipeline.sv ====
module tb_pipeline;
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    localparam int DMEM_WORDS = 64;

    logic      ui_clk_from_ddr;
    logic      reset;
    logic      instr_valid;
    word_t     instr;
    logic      instr_ready;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // Program and reference model state
    word_t     prog_q[$];
    word_t     ref_regs [32];
    word_t     ref_mem [DMEM_WORDS];
    int        exp_edge_q[$];
    reg_addr_t exp_rd_q[$];
    word_t     exp_data_q[$];
    reg_addr_t last_load_rd = '0;
    int        stall_edge = -1;
    logic      started = 1'b0;

    int cycle = 0;
    int max_cycles = 0;
    int errors = 0;
    int checks = 0;

    pipeline_top #(
        .DMEM_WORDS ( DMEM_WORDS )
    ) dut_i (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .instr_valid     ( instr_valid     ),
        .instr           ( instr           ),
        .instr_ready     ( instr_ready     ),
        .wb_valid        ( wb_valid        ),
        .wb_rd           ( wb_rd           ),
        .wb_data         ( wb_data         )
    );

    initial begin
        ui_clk_from_ddr = 1'b0;
        forever #20 ui_clk_from_ddr = ~ui_clk_from_ddr;
    end

    //////////////////////////////////////////////////
    // Instruction assembly
    //////////////////////////////////////////////////

    function automatic word_t rtype(input funct_t fn, input int rd, input int rs, input int rt);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t itype(input opcode_t op, input int rs, input int rt,
                                    input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [15:0] random_imm();
        return 16'($urandom_range(0, 16'hffff));
    endfunction

    task automatic build_program();
        // Seed values with distance one and two dependencies on $1
        prog_q.push_back(itype(OP_ADDI, 0, 1, random_imm()));
        prog_q.push_back(itype(OP_ADDI, 1, 2, random_imm()));
        prog_q.push_back(itype(OP_ADDI, 1, 3, random_imm()));
        prog_q.push_back(itype(OP_ADDI, 0, 4, random_imm()));
        prog_q.push_back(itype(OP_ADDI, 0, 5, random_imm()));
        prog_q.push_back(itype(OP_ADDI, 0, 6, 16'd16));
        // ALU chain through MEM and WB forwarding
        prog_q.push_back(rtype(FN_ADD, 7, 1, 2));
        prog_q.push_back(rtype(FN_SUB, 8, 7, 3));
        prog_q.push_back(rtype(FN_AND, 9, 7, 8));
        prog_q.push_back(rtype(FN_OR, 10, 9, 4));
        prog_q.push_back(rtype(FN_SLT, 11, 10, 5));
        prog_q.push_back(rtype(FN_SLT, 12, 5, 10));
        prog_q.push_back(rtype(FN_ADD, 13, 11, 12));
        // Stores, then loads from the same words
        prog_q.push_back(itype(OP_SW, 6, 7, 16'd0));
        prog_q.push_back(itype(OP_SW, 6, 8, 16'd4));
        prog_q.push_back(rtype(FN_ADD, 14, 1, 1));
        prog_q.push_back(itype(OP_LW, 6, 15, 16'd0));
        prog_q.push_back(itype(OP_LW, 6, 16, 16'd4));
        prog_q.push_back(rtype(FN_ADD, 17, 16, 15));
        // Load-use on rs, on sw data and on addi
        prog_q.push_back(itype(OP_LW, 6, 18, 16'd0));
        prog_q.push_back(rtype(FN_SUB, 19, 18, 1));
        prog_q.push_back(itype(OP_LW, 6, 20, 16'd4));
        prog_q.push_back(itype(OP_SW, 6, 20, 16'd8));
        prog_q.push_back(itype(OP_LW, 6, 21, 16'd8));
        prog_q.push_back(itype(OP_ADDI, 21, 22, random_imm()));
        // addi only overwrites the loaded register, no stall
        prog_q.push_back(itype(OP_LW, 6, 25, 16'd0));
        prog_q.push_back(itype(OP_ADDI, 1, 25, 16'd5));
        // Register 0 targets and no-op encodings
        prog_q.push_back(rtype(FN_ADD, 0, 1, 2));
        prog_q.push_back(itype(OP_ADDI, 0, 0, 16'd7));
        prog_q.push_back(itype(OP_LW, 6, 0, 16'd0));
        prog_q.push_back(rtype(FN_ADD, 28, 0, 1));
        prog_q.push_back(32'hfc00_0000);
        prog_q.push_back(rtype(6'd0, 26, 1, 2));
        prog_q.push_back(rtype(FN_ADD, 26, 0, 1));
        prog_q.push_back(rtype(FN_OR, 27, 0, 0));
        // Negative operands for slt
        prog_q.push_back(rtype(FN_SUB, 29, 0, 1));
        prog_q.push_back(rtype(FN_SLT, 30, 29, 1));
        prog_q.push_back(rtype(FN_AND, 31, 30, 7));
        prog_q.push_back(rtype(FN_ADD, 1, 31, 29));
        prog_q.push_back(itype(OP_SW, 6, 1, 16'd12));
        prog_q.push_back(itype(OP_LW, 6, 2, 16'd12));
    endtask

    //////////////////////////////////////////////////
    // Reference model and checks
    //////////////////////////////////////////////////

    // In-order execution of one accepted instruction
    task automatic execute_ref(input word_t w, input int edge_no);
        opcode_t     op;
        funct_t      fn;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   dest;
        word_t       a;
        word_t       b;
        word_t       imm;
        word_t       val;
        logic        writes;
        logic        hazard;
        int unsigned idx;
        op     = w[31:26];
        rs     = w[25:21];
        rt     = w[20:16];
        fn     = w[5:0];
        imm    = {{16{w[15]}}, w[15:0]};
        a      = ref_regs[rs];
        b      = ref_regs[rt];
        dest   = w[15:11];
        val    = '0;
        writes = 1'b0;
        hazard = (last_load_rd != '0) && ((rs == last_load_rd) ||
                 ((op == OP_RTYPE || op == OP_SW) && rt == last_load_rd));
        case (op)
            OP_RTYPE: begin
                writes = 1'b1;
                case (fn)
                    FN_ADD:  val = a + b;
                    FN_SUB:  val = a - b;
                    FN_AND:  val = a & b;
                    FN_OR:   val = a | b;
                    FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: writes = 1'b0;
                endcase
            end
            OP_ADDI: begin
                writes = 1'b1;
                dest   = rt;
                val    = a + imm;
            end
            OP_LW: begin
                writes = 1'b1;
                dest   = rt;
                idx    = ((a + imm) >> 2) % DMEM_WORDS;
                val    = ref_mem[idx];
            end
            OP_SW: begin
                idx          = ((a + imm) >> 2) % DMEM_WORDS;
                ref_mem[idx] = b;
            end
            default: ;
        endcase
        // The dependent instruction waits one cycle in IF/ID
        if (hazard) begin
            stall_edge = edge_no + 1;
        end
        if (writes && dest != '0) begin
            ref_regs[dest] = val;
            exp_edge_q.push_back(edge_no + 4 + int'(hazard));
            exp_rd_q.push_back(dest);
            exp_data_q.push_back(val);
        end
        last_load_rd = (op == OP_LW) ? rt : '0;
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Samples pre-edge values, so DUT updates on this edge are not seen
    always @(posedge ui_clk_from_ddr) begin
        cycle++;
        if (!reset) begin
            check_value("instr_ready", instr_ready, (cycle != stall_edge) ? 1 : 0);
            if (!started) begin
                check_value("wb_valid", wb_valid, 0);
            end
            if (wb_valid) begin
                checks++;
                assert (exp_edge_q.size() != 0) else begin
                    $display("Unexpected write-back to r%0d at cycle %0d", wb_rd, cycle);
                    errors++;
                end
                if (exp_edge_q.size() != 0) begin
                    checks++;
                    assert (exp_edge_q[0] == cycle) else begin
                        $display("Write-back to r%0d at cycle %0d, expected at cycle %0d",
                                 wb_rd, cycle, exp_edge_q[0]);
                        errors++;
                    end
                    check_value("wb_rd", wb_rd, exp_rd_q.pop_front());
                    check_value("wb_data", wb_data, exp_data_q.pop_front());
                    void'(exp_edge_q.pop_front());
                end
            end else if (exp_edge_q.size() != 0) begin
                checks++;
                assert (exp_edge_q[0] >= cycle) else begin
                    $display("Missing write-back to r%0d due at cycle %0d",
                             exp_rd_q[0], exp_edge_q[0]);
                    errors++;
                end
                if (exp_edge_q[0] < cycle) begin
                    void'(exp_edge_q.pop_front());
                    void'(exp_rd_q.pop_front());
                    void'(exp_data_q.pop_front());
                end
            end
            if (instr_valid && instr_ready) begin
                started = 1'b1;
                execute_ref(instr, cycle);
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        int idx;
        void'($urandom(89));
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        build_program();
        max_cycles = prog_q.size() * 4 + 50;

        repeat (2) @(posedge ui_clk_from_ddr);
        @(negedge ui_clk_from_ddr);
        reset = 1'b0;
        // Idle a little so the post-reset state is observed
        repeat (2) @(negedge ui_clk_from_ddr);

        idx         = 0;
        instr_valid = 1'b1;
        instr       = prog_q[0];
        while (idx < prog_q.size()) begin
            @(posedge ui_clk_from_ddr);
            if (instr_ready) begin
                idx++;
            end
            @(negedge ui_clk_from_ddr);
            if (idx < prog_q.size()) begin
                instr = prog_q[idx];
            end else begin
                instr_valid = 1'b0;
                instr       = '0;
            end
        end

        while (exp_edge_q.size() != 0) begin
            @(posedge ui_clk_from_ddr);
        end
        // Room for any stray pulse to show up
        repeat (6) @(posedge ui_clk_from_ddr);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Run limit
    initial begin
        wait (max_cycles > 0);
        while (cycle < max_cycles) begin
            @(posedge ui_clk_from_ddr);
        end
        $display("Timeout after %0d cycles with %0d write-backs outstanding",
                 cycle, exp_edge_q.size());
        errors++;
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== rtl/pipeline_top.sv ====
module pipeline_top #(
    parameter int DMEM_WORDS = 64
) (
    input  logic               ui_clk_from_ddr,
    input  logic               reset,
    input  logic               instr_valid,
    input  cpu_pkg::word_t     instr,
    output logic               instr_ready,
    output logic               wb_valid,
    output cpu_pkg::reg_addr_t wb_rd,
    output cpu_pkg::word_t     wb_data
);
    import cpu_pkg::*;

    //////////////////////////////////////////////////
    // Stage wiring
    //////////////////////////////////////////////////

    // ID/EX
    logic      idex_valid;
    alu_op_t   idex_alu_op;
    logic      idex_use_imm;
    word_t     idex_imm;
    logic      idex_mem_r;
    logic      idex_mem_w;
    logic      idex_reg_w;
    reg_addr_t idex_rs;
    reg_addr_t idex_rt;
    reg_addr_t idex_rd;
    word_t     idex_rs_data;
    word_t     idex_rt_data;

    // Hazard feedback from EX
    logic      ex_load;
    reg_addr_t ex_rd;

    // EX/MEM
    logic      exmem_valid;
    logic      exmem_mem_r;
    logic      exmem_mem_w;
    logic      exmem_reg_w;
    reg_addr_t exmem_rd;
    word_t     exmem_result;
    word_t     exmem_store_data;

    id_stage u_id_stage (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .instr_valid     ( instr_valid     ),
        .instr           ( instr           ),
        .instr_ready     ( instr_ready     ),
        .ex_load         ( ex_load         ),
        .ex_rd           ( ex_rd           ),
        .wb_write        ( wb_valid        ),
        .wb_rd           ( wb_rd           ),
        .wb_data         ( wb_data         ),
        .idex_valid      ( idex_valid      ),
        .idex_alu_op     ( idex_alu_op     ),
        .idex_use_imm    ( idex_use_imm    ),
        .idex_imm        ( idex_imm        ),
        .idex_mem_r      ( idex_mem_r      ),
        .idex_mem_w      ( idex_mem_w      ),
        .idex_reg_w      ( idex_reg_w      ),
        .idex_rs         ( idex_rs         ),
        .idex_rt         ( idex_rt         ),
        .idex_rd         ( idex_rd         ),
        .idex_rs_data    ( idex_rs_data    ),
        .idex_rt_data    ( idex_rt_data    )
    );

    ex_stage u_ex_stage (
        .ui_clk_from_ddr  ( ui_clk_from_ddr  ),
        .reset            ( reset            ),
        .idex_valid       ( idex_valid       ),
        .idex_alu_op      ( idex_alu_op      ),
        .idex_use_imm     ( idex_use_imm     ),
        .idex_imm         ( idex_imm         ),
        .idex_mem_r       ( idex_mem_r       ),
        .idex_mem_w       ( idex_mem_w       ),
        .idex_reg_w       ( idex_reg_w       ),
        .idex_rs          ( idex_rs          ),
        .idex_rt          ( idex_rt          ),
        .idex_rd          ( idex_rd          ),
        .idex_rs_data     ( idex_rs_data     ),
        .idex_rt_data     ( idex_rt_data     ),
        .wb_reg_w         ( wb_valid         ),
        .wb_rd            ( wb_rd            ),
        .wb_data          ( wb_data          ),
        .ex_load          ( ex_load          ),
        .ex_rd            ( ex_rd            ),
        .exmem_valid      ( exmem_valid      ),
        .exmem_mem_r      ( exmem_mem_r      ),
        .exmem_mem_w      ( exmem_mem_w      ),
        .exmem_reg_w      ( exmem_reg_w      ),
        .exmem_rd         ( exmem_rd         ),
        .exmem_result     ( exmem_result     ),
        .exmem_store_data ( exmem_store_data )
    );

    // Write-back triple is also the top-level output
    mem_stage #(
        .DMEM_WORDS ( DMEM_WORDS )
    ) u_mem_stage (
        .ui_clk_from_ddr  ( ui_clk_from_ddr  ),
        .reset            ( reset            ),
        .exmem_valid      ( exmem_valid      ),
        .exmem_mem_r      ( exmem_mem_r      ),
        .exmem_mem_w      ( exmem_mem_w      ),
        .exmem_reg_w      ( exmem_reg_w      ),
        .exmem_rd         ( exmem_rd         ),
        .exmem_result     ( exmem_result     ),
        .exmem_store_data ( exmem_store_data ),
        .wb_valid         ( wb_valid         ),
        .wb_rd            ( wb_rd            ),
        .wb_data          ( wb_data          )
    );

endmodule

// ==== rtl/mem_stage.sv ====
module mem_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic               ui_clk_from_ddr,
    input  logic               reset,
    input  logic               exmem_valid,
    input  logic               exmem_mem_r,
    input  logic               exmem_mem_w,
    input  logic               exmem_reg_w,
    input  cpu_pkg::reg_addr_t exmem_rd,
    input  cpu_pkg::word_t     exmem_result,
    input  cpu_pkg::word_t     exmem_store_data,
    output logic               wb_valid,
    output cpu_pkg::reg_addr_t wb_rd,
    output cpu_pkg::word_t     wb_data
);
    import cpu_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    word_t         dmem [DMEM_WORDS];
    logic [AW-1:0] idx;
    word_t         load_data;

    // Word index, upper address bits wrap
    assign idx       = exmem_result[AW+1:2];
    assign load_data = dmem[idx];

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (exmem_valid && exmem_mem_w) begin
            dmem[idx] <= exmem_store_data;
        end
    end

    // MEM/WB
    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= exmem_valid && exmem_reg_w;
        end
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        wb_rd   <= exmem_rd;
        wb_data <= exmem_mem_r ? load_data : exmem_result;
    end

endmodule

// ==== rtl/ex_stage.sv ====
module ex_stage (
    input  logic               ui_clk_from_ddr,
    input  logic               reset,
    input  logic               idex_valid,
    input  cpu_pkg::alu_op_t   idex_alu_op,
    input  logic               idex_use_imm,
    input  cpu_pkg::word_t     idex_imm,
    input  logic               idex_mem_r,
    input  logic               idex_mem_w,
    input  logic               idex_reg_w,
    input  cpu_pkg::reg_addr_t idex_rs,
    input  cpu_pkg::reg_addr_t idex_rt,
    input  cpu_pkg::reg_addr_t idex_rd,
    input  cpu_pkg::word_t     idex_rs_data,
    input  cpu_pkg::word_t     idex_rt_data,
    input  logic               wb_reg_w,
    input  cpu_pkg::reg_addr_t wb_rd,
    input  cpu_pkg::word_t     wb_data,
    output logic               ex_load,
    output cpu_pkg::reg_addr_t ex_rd,
    output logic               exmem_valid,
    output logic               exmem_mem_r,
    output logic               exmem_mem_w,
    output logic               exmem_reg_w,
    output cpu_pkg::reg_addr_t exmem_rd,
    output cpu_pkg::word_t     exmem_result,
    output cpu_pkg::word_t     exmem_store_data
);
    import cpu_pkg::*;

    fwd_sel_t sel_a;
    fwd_sel_t sel_b;
    word_t    op_a;
    word_t    fwd_b;
    word_t    op_b;
    word_t    alu_out;

    //////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////

    forward_unit u_forward_unit (
        .rs        ( idex_rs     ),
        .rt        ( idex_rt     ),
        .mem_reg_w ( exmem_reg_w ),
        .mem_rd    ( exmem_rd    ),
        .wb_reg_w  ( wb_reg_w    ),
        .wb_rd     ( wb_rd       ),
        .sel_a     ( sel_a       ),
        .sel_b     ( sel_b       )
    );

    always_comb begin
        case (sel_a)
            FWD_MEM: op_a = exmem_result;
            FWD_WB:  op_a = wb_data;
            default: op_a = idex_rs_data;
        endcase
        case (sel_b)
            FWD_MEM: fwd_b = exmem_result;
            FWD_WB:  fwd_b = wb_data;
            default: fwd_b = idex_rt_data;
        endcase
    end

    // Forwarded rt is still the store data when B takes the immediate
    assign op_b = idex_use_imm ? idex_imm : fwd_b;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    always_comb begin
        case (idex_alu_op)
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            default: alu_out = op_a + op_b;
        endcase
    end

    // Seen by ID for the load-use check
    assign ex_load = idex_valid && idex_mem_r && idex_reg_w;
    assign ex_rd   = idex_rd;

    //////////////////////////////////////////////////
    // EX/MEM
    //////////////////////////////////////////////////

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            exmem_valid <= 1'b0;
            exmem_mem_r <= 1'b0;
            exmem_mem_w <= 1'b0;
            exmem_reg_w <= 1'b0;
        end else begin
            exmem_valid <= idex_valid;
            exmem_mem_r <= idex_valid && idex_mem_r;
            exmem_mem_w <= idex_valid && idex_mem_w;
            exmem_reg_w <= idex_valid && idex_reg_w;
        end
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        exmem_rd         <= idex_rd;
        exmem_result     <= alu_out;
        exmem_store_data <= fwd_b;
    end

endmodule

// ==== rtl/id_stage.sv ====
module id_stage (
    input  logic               ui_clk_from_ddr,
    input  logic               reset,
    input  logic               instr_valid,
    input  cpu_pkg::word_t     instr,
    output logic               instr_ready,
    input  logic               ex_load,
    input  cpu_pkg::reg_addr_t ex_rd,
    input  logic               wb_write,
    input  cpu_pkg::reg_addr_t wb_rd,
    input  cpu_pkg::word_t     wb_data,
    output logic               idex_valid,
    output cpu_pkg::alu_op_t   idex_alu_op,
    output logic               idex_use_imm,
    output cpu_pkg::word_t     idex_imm,
    output logic               idex_mem_r,
    output logic               idex_mem_w,
    output logic               idex_reg_w,
    output cpu_pkg::reg_addr_t idex_rs,
    output cpu_pkg::reg_addr_t idex_rt,
    output cpu_pkg::reg_addr_t idex_rd,
    output cpu_pkg::word_t     idex_rs_data,
    output cpu_pkg::word_t     idex_rt_data
);
    import cpu_pkg::*;

    logic      ifid_valid;
    word_t     ifid_instr;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dest;
    word_t     rs_data;
    word_t     rt_data;
    word_t     imm_ext;
    alu_op_t   alu_op;
    logic      use_imm;
    logic      mem_r;
    logic      mem_w;
    logic      reg_w;
    logic      dest_is_rt;
    logic      rt_used;
    logic      stall;
    logic      id_go;

    //////////////////////////////////////////////////
    // IF/ID
    //////////////////////////////////////////////////

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            ifid_valid <= 1'b0;
        end else if (instr_ready) begin
            ifid_valid <= instr_valid;
        end
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        if (instr_ready && instr_valid) begin
            ifid_instr <= instr;
        end
    end

    //////////////////////////////////////////////////
    // Decode and register read
    //////////////////////////////////////////////////

    assign rs      = ifid_instr[RS_HI:RS_LO];
    assign rt      = ifid_instr[RT_HI:RT_LO];
    assign dest    = dest_is_rt ? rt : ifid_instr[RD_HI:RD_LO];
    assign imm_ext = {{16{ifid_instr[IMM_HI]}}, ifid_instr[IMM_HI:IMM_LO]};

    decoder u_decoder (
        .instr      ( ifid_instr ),
        .alu_op     ( alu_op     ),
        .use_imm    ( use_imm    ),
        .mem_r      ( mem_r      ),
        .mem_w      ( mem_w      ),
        .reg_w      ( reg_w      ),
        .dest_is_rt ( dest_is_rt )
    );

    reg_file u_reg_file (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .rs              ( rs              ),
        .rt              ( rt              ),
        .rs_data         ( rs_data         ),
        .rt_data         ( rt_data         ),
        .w_en            ( wb_write        ),
        .w_addr          ( wb_rd           ),
        .w_data          ( wb_data         )
    );

    // Load-use hazard against the lw now in EX
    // rt is only a source for R-type and sw
    assign rt_used     = !use_imm || mem_w;
    assign stall       = ifid_valid && ex_load &&
                         ((rs == ex_rd) || (rt_used && rt == ex_rd));
    assign instr_ready = !stall;
    assign id_go       = ifid_valid && !stall;

    //////////////////////////////////////////////////
    // ID/EX
    //////////////////////////////////////////////////

    // A stall leaves a bubble with all write enables low
    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            idex_valid <= 1'b0;
            idex_mem_r <= 1'b0;
            idex_mem_w <= 1'b0;
            idex_reg_w <= 1'b0;
        end else begin
            idex_valid <= id_go;
            idex_mem_r <= id_go && mem_r;
            idex_mem_w <= id_go && mem_w;
            idex_reg_w <= id_go && reg_w;
        end
    end

    always_ff @(posedge ui_clk_from_ddr) begin
        idex_alu_op  <= alu_op;
        idex_use_imm <= use_imm;
        idex_imm     <= imm_ext;
        idex_rs      <= rs;
        idex_rt      <= rt;
        idex_rd      <= dest;
        idex_rs_data <= rs_data;
        idex_rt_data <= rt_data;
    end

endmodule

// ==== rtl/forward_unit.sv ====
module forward_unit (
    input  cpu_pkg::reg_addr_t rs,
    input  cpu_pkg::reg_addr_t rt,
    input  logic               mem_reg_w,
    input  cpu_pkg::reg_addr_t mem_rd,
    input  logic               wb_reg_w,
    input  cpu_pkg::reg_addr_t wb_rd,
    output cpu_pkg::fwd_sel_t  sel_a,
    output cpu_pkg::fwd_sel_t  sel_b
);
    import cpu_pkg::*;

    // Youngest producer wins, so MEM is checked before WB
    function automatic fwd_sel_t pick(
        input reg_addr_t src,
        input logic      m_reg_w,
        input reg_addr_t m_rd,
        input logic      w_reg_w,
        input reg_addr_t w_rd
    );
        if (src == '0) begin
            return FWD_NONE;
        end else if (m_reg_w && m_rd == src) begin
            return FWD_MEM;
        end else if (w_reg_w && w_rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign sel_a = pick(rs, mem_reg_w, mem_rd, wb_reg_w, wb_rd);
    assign sel_b = pick(rt, mem_reg_w, mem_rd, wb_reg_w, wb_rd);

endmodule

// ==== rtl/reg_file.sv ====
module reg_file (
    input  logic               ui_clk_from_ddr,
    input  logic               reset,
    input  cpu_pkg::reg_addr_t rs,
    input  cpu_pkg::reg_addr_t rt,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data,
    input  logic               w_en,
    input  cpu_pkg::reg_addr_t w_addr,
    input  cpu_pkg::word_t     w_data
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en && w_addr != '0) begin
            regs[w_addr] <= w_data;
        end
    end

    // Write-through so ID sees the value retiring in this cycle
    assign rs_data = (rs == '0) ? '0 :
                     (w_en && w_addr == rs) ? w_data : regs[rs];
    assign rt_data = (rt == '0) ? '0 :
                     (w_en && w_addr == rt) ? w_data : regs[rt];

endmodule

// ==== rtl/decoder.sv ====
module decoder (
    input  cpu_pkg::word_t   instr,
    output cpu_pkg::alu_op_t alu_op,
    output logic             use_imm,
    output logic             mem_r,
    output logic             mem_w,
    output logic             reg_w,
    output logic             dest_is_rt
);
    import cpu_pkg::*;

    opcode_t opcode;
    funct_t  funct;

    assign opcode = instr[OP_HI:OP_LO];
    assign funct  = instr[FN_HI:FN_LO];

    always_comb begin
        // Anything not recognised falls through as a no-op
        alu_op     = ALU_ADD;
        use_imm    = 1'b0;
        mem_r      = 1'b0;
        mem_w      = 1'b0;
        reg_w      = 1'b0;
        dest_is_rt = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                reg_w = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_w = 1'b0;
                endcase
            end
            OP_ADDI: begin
                use_imm    = 1'b1;
                reg_w      = 1'b1;
                dest_is_rt = 1'b1;
            end
            OP_LW: begin
                use_imm    = 1'b1;
                mem_r      = 1'b1;
                reg_w      = 1'b1;
                dest_is_rt = 1'b1;
            end
            // Address is rs + imm, data comes from rt
            OP_SW: begin
                use_imm = 1'b1;
                mem_w   = 1'b1;
            end
            default: ;
        endcase
        // Writes to $0 are dropped here
        if ((dest_is_rt ? instr[RT_HI:RT_LO] : instr[RD_HI:RD_LO]) == '0) begin
            reg_w = 1'b0;
        end
    end

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // Source of an EX operand
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    localparam opcode_t OP_RTYPE = 6'd0;
    localparam opcode_t OP_ADDI  = 6'd8;
    localparam opcode_t OP_LW    = 6'd35;
    localparam opcode_t OP_SW    = 6'd43;

    localparam funct_t FN_ADD = 6'd32;
    localparam funct_t FN_SUB = 6'd34;
    localparam funct_t FN_AND = 6'd36;
    localparam funct_t FN_OR  = 6'd37;
    localparam funct_t FN_SLT = 6'd42;

    // Instruction field positions
    localparam int OP_HI  = 31;
    localparam int OP_LO  = 26;
    localparam int RS_HI  = 25;
    localparam int RS_LO  = 21;
    localparam int RT_HI  = 20;
    localparam int RT_LO  = 16;
    localparam int RD_HI  = 15;
    localparam int RD_LO  = 11;
    localparam int FN_HI  = 5;
    localparam int FN_LO  = 0;
    localparam int IMM_HI = 15;
    localparam int IMM_LO = 0;

endpackage
